// File: verilog/ifu_pkg.sv
/*
  shared widths, encodings and fixed addresses of the fetch stage
  FIFO_DEPTH must be 2 or more; it also caps the bus requests in flight
*/
`default_nettype none

package ifu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned FIFO_DEPTH = 2;
  // count holds 0..FIFO_DEPTH, pointer indexes 0..FIFO_DEPTH-1
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);
  localparam logic [FIFO_CNT_W-1:0] CNT_ONE   = FIFO_CNT_W'(1);
  localparam logic [FIFO_PTR_W-1:0] PTR_LAST  = FIFO_PTR_W'(FIFO_DEPTH - 1);

  // fixed entry points
  localparam logic [7:0]      BOOT_OFFSET       = 8'h80;
  localparam logic [XLEN-1:0] DM_HALT_ADDR      = 32'h1A110800;
  localparam logic [XLEN-1:0] DM_EXCEPTION_ADDR = 32'h1A110808;
  // every internal interrupt shares this vector slot
  localparam logic [4:0]      NMI_LOWER_CAUSE   = 5'd31;

  ////////////////////////////////////////////////////////////////////////////
  // selector encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  typedef struct packed {
    logic       irq_int;
    logic       irq_ext;
    logic [4:0] lower_cause;
  } exc_cause_t;

  // one returned instruction word, 65 bits
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rdata;
    logic            err;
  } fetch_entry_t;

endpackage

`default_nettype wire

// File: verilog/ifu_pc_select.sv
/*
  next fetch address mux, purely combinational
  boot address and mtvec are taken as 256-byte aligned, low byte is ignored
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_pc_select (
  input  wire logic [ifu_pkg::XLEN-1:0] boot_addr_i,
  input  wire ifu_pkg::pc_sel_e         pc_mux_i,
  input  wire ifu_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  wire ifu_pkg::exc_cause_t      exc_cause_i,
  input  wire logic [ifu_pkg::XLEN-1:0] branch_target_ex_i,
  input  wire logic [ifu_pkg::XLEN-1:0] csr_mepc_i,
  input  wire logic [ifu_pkg::XLEN-1:0] csr_depc_i,
  input  wire logic [ifu_pkg::XLEN-1:0] csr_mtvec_i,
  input  wire logic                     pc_set_i,
  output logic      [ifu_pkg::XLEN-1:0] fetch_addr_n_o,
  output logic                          csr_mtvec_init_o
);

  logic [4:0]               irq_vec;
  logic [ifu_pkg::XLEN-1:0] exc_pc;
  logic [ifu_pkg::XLEN-1:0] boot_pc;

  // internal interrupts fold onto the NMI slot
  assign irq_vec = exc_cause_i.irq_int ? ifu_pkg::NMI_LOWER_CAUSE
                                       : exc_cause_i.lower_cause;

  assign boot_pc = {boot_addr_i[31:8], ifu_pkg::BOOT_OFFSET};

  // handler address
  always_comb begin
    case (exc_pc_mux_i)
      ifu_pkg::EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
      // vectored mode, 4 bytes per slot
      ifu_pkg::EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_vec, 2'b00};
      ifu_pkg::EXC_PC_DBD:     exc_pc = ifu_pkg::DM_HALT_ADDR;
      ifu_pkg::EXC_PC_DBG_EXC: exc_pc = ifu_pkg::DM_EXCEPTION_ADDR;
      default:                 exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  // next fetch target
  always_comb begin
    case (pc_mux_i)
      ifu_pkg::PC_BOOT: fetch_addr_n_o = boot_pc;
      ifu_pkg::PC_JUMP: fetch_addr_n_o = branch_target_ex_i;
      ifu_pkg::PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap
      ifu_pkg::PC_ERET: fetch_addr_n_o = csr_mepc_i;
      // return from debug mode
      ifu_pkg::PC_DRET: fetch_addr_n_o = csr_depc_i;
      default:          fetch_addr_n_o = boot_pc;
    endcase
  end

  // CSR file loads mtvec on the boot redirect only
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == ifu_pkg::PC_BOOT);

endmodule

`default_nettype wire

// File: verilog/ifu_fetch_fifo.sv
/*
  circular FIFO of fetched words, FIFO_DEPTH entries, no bypass
  a push is visible at the head one cycle later; clear wins over push
  a push into a full FIFO is dropped
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_fifo (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           clear_i,
  input  wire logic                           push_i,
  input  wire ifu_pkg::fetch_entry_t          push_entry_i,
  input  wire logic                           pop_i,
  output logic                                valid_o,
  output ifu_pkg::fetch_entry_t               head_o,
  output logic [ifu_pkg::FIFO_CNT_W-1:0]      count_o
);

  ifu_pkg::fetch_entry_t              mem_q [ifu_pkg::FIFO_DEPTH];
  logic [ifu_pkg::FIFO_PTR_W-1:0]     rptr_q;
  logic [ifu_pkg::FIFO_PTR_W-1:0]     wptr_q;
  logic [ifu_pkg::FIFO_CNT_W-1:0]     count_q;
  logic                               push_ok;
  logic                               pop_ok;

  // wrap also for depths that are not a power of two
  function automatic logic [ifu_pkg::FIFO_PTR_W-1:0] ptr_next(
    input logic [ifu_pkg::FIFO_PTR_W-1:0] ptr
  );
    if (ptr == ifu_pkg::PTR_LAST) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign pop_ok  = pop_i & (count_q != '0);
  assign push_ok = push_i & (count_q != ifu_pkg::FIFO_FULL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < ifu_pkg::FIFO_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (clear_i) begin
      // flush, stored words become unreachable
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) begin
        mem_q[wptr_q] <= push_entry_i;
        wptr_q        <= ptr_next(wptr_q);
      end
      if (pop_ok) begin
        rptr_q <= ptr_next(rptr_q);
      end
      // simultaneous push and pop leaves the count alone
      if (push_ok && !pop_ok) begin
        count_q <= count_q + ifu_pkg::CNT_ONE;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - ifu_pkg::CNT_ONE;
      end
    end
  end

  assign valid_o = (count_q != '0);
  assign head_o  = mem_q[rptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

// File: verilog/ifu_prefetch_buffer.sv
/*
  word fetch over a request/grant/rvalid bus, responses in grant order
  FIFO entries plus requests in flight never exceed FIFO_DEPTH
  after a redirect, responses of older requests are dropped
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_prefetch_buffer (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     req_i,
  input  wire logic                     branch_i,
  input  wire logic [ifu_pkg::XLEN-1:0] branch_addr_i,
  input  wire logic                     ready_i,
  output logic                          valid_o,
  output ifu_pkg::fetch_entry_t         fetch_o,
  output logic                          instr_req_o,
  output logic      [ifu_pkg::XLEN-1:0] instr_addr_o,
  input  wire logic                     instr_gnt_i,
  input  wire logic                     instr_rvalid_i,
  input  wire logic [ifu_pkg::XLEN-1:0] instr_rdata_i,
  input  wire logic                     instr_bus_err_i,
  output logic                          busy_o
);

  logic [ifu_pkg::XLEN-1:0]       branch_addr_al;
  logic [ifu_pkg::XLEN-1:0]       fetch_addr_q;
  logic [ifu_pkg::XLEN-1:0]       rsp_addr_q;
  logic [ifu_pkg::FIFO_CNT_W-1:0] outst_q;
  logic [ifu_pkg::FIFO_CNT_W-1:0] discard_q;
  logic [ifu_pkg::FIFO_CNT_W-1:0] fifo_count;
  logic [ifu_pkg::FIFO_CNT_W:0]   slots_used;
  logic                           space;
  logic                           req_hold_q;
  logic                           gnt_acc;
  logic                           rsp_keep;
  ifu_pkg::fetch_entry_t          push_entry;

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign branch_addr_al = {branch_addr_i[ifu_pkg::XLEN-1:2], 2'b00};

  // one spare bit so the sum cannot wrap
  assign slots_used = {1'b0, fifo_count} + {1'b0, outst_q};
  assign space      = slots_used < {1'b0, ifu_pkg::FIFO_FULL};

  // an ungranted request stays up even if req_i drops
  assign instr_req_o  = (req_i | req_hold_q) & space;
  // the redirect target goes out in the redirect cycle itself
  assign instr_addr_o = branch_i ? branch_addr_al : fetch_addr_q;
  assign gnt_acc      = instr_req_o & instr_gnt_i;

  assign busy_o = instr_req_o | (outst_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_hold_q   <= 1'b0;
      fetch_addr_q <= '0;
      outst_q      <= '0;
    end else begin
      req_hold_q <= instr_req_o & ~instr_gnt_i;
      if (gnt_acc) begin
        fetch_addr_q <= instr_addr_o + 32'd4;
      end else if (branch_i) begin
        fetch_addr_q <= branch_addr_al;
      end
      // grant opens a slot on the bus, rvalid closes one
      if (gnt_acc && !instr_rvalid_i) begin
        outst_q <= outst_q + ifu_pkg::CNT_ONE;
      end else if (instr_rvalid_i && !gnt_acc) begin
        outst_q <= outst_q - ifu_pkg::CNT_ONE;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////////////////////

  // only responses of the current stream enter the FIFO
  assign rsp_keep = instr_rvalid_i & (discard_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      discard_q  <= '0;
      rsp_addr_q <= '0;
    end else begin
      if (branch_i) begin
        // everything still in flight belongs to the old stream,
        // a response arriving now is gone already
        discard_q  <= instr_rvalid_i ? outst_q - ifu_pkg::CNT_ONE : outst_q;
        rsp_addr_q <= branch_addr_al;
      end else if (instr_rvalid_i) begin
        if (discard_q != '0) begin
          discard_q <= discard_q - ifu_pkg::CNT_ONE;
        end else begin
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
      end
    end
  end

  assign push_entry.addr  = rsp_addr_q;
  assign push_entry.rdata = instr_rdata_i;
  assign push_entry.err   = instr_bus_err_i;

  ifu_fetch_fifo fifo_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (branch_i),
    .push_i       (rsp_keep),
    .push_entry_i (push_entry),
    .pop_i        (ready_i & valid_o),
    .valid_o      (valid_o),
    .head_o       (fetch_o),
    .count_o      (fifo_count)
  );

endmodule

`default_nettype wire

// File: verilog/ifu_if_id_reg.sv
/*
  IF-ID register with valid/new flags and PC increment check
  nothing is accepted in a redirect cycle
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_if_id_reg (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     fetch_valid_i,
  input  wire ifu_pkg::fetch_entry_t    fetch_i,
  input  wire logic                     pmp_err_if_i,
  input  wire logic                     pc_set_i,
  input  wire logic                     id_in_ready_i,
  input  wire logic                     instr_valid_clear_i,
  output logic                          fetch_ready_o,
  output logic                          instr_valid_id_o,
  output logic                          instr_new_id_o,
  output logic      [ifu_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                          instr_fetch_err_o,
  output logic      [ifu_pkg::XLEN-1:0] pc_id_o,
  output logic                          pc_mismatch_alert_o
);

  logic                     accept;
  logic                     fetch_err;
  logic                     valid_d;
  logic                     seq_q;
  logic                     seq_d;
  logic [ifu_pkg::XLEN-1:0] pc_id_incr;

  // a redirect squashes the head
  assign fetch_ready_o = id_in_ready_i & ~pc_set_i;
  assign accept        = fetch_valid_i & fetch_ready_o;

  // bus and pmp errors are reported the same way
  assign fetch_err = fetch_i.err | pmp_err_if_i;

  // valid holds until ID clears it
  assign valid_d = accept | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= accept;
      if (accept) begin
        instr_rdata_id_o  <= fetch_i.rdata;
        instr_fetch_err_o <= fetch_err;
        pc_id_o           <= fetch_i.addr;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // PC consistency
  ////////////////////////////////////////////////////////////////////////////

  // no check after reset, a redirect or a faulting fetch
  assign seq_d = (seq_q | accept) & ~pc_set_i & ~(accept & fetch_err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_id_incr = pc_id_o + 32'd4;

  // head of the FIFO must follow the instruction in ID
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_i.addr != pc_id_incr);

endmodule

`default_nettype wire

// File: verilog/ifu_if_stage.sv
/*
  instruction fetch stage top, word-aligned 32-bit instructions only
  pc_set_i is a single-cycle strobe, targets are taken as word aligned
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_if_stage (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic [ifu_pkg::XLEN-1:0] boot_addr_i,
  input  wire logic                     req_i,
  // instruction bus
  output logic                          instr_req_o,
  output logic      [ifu_pkg::XLEN-1:0] instr_addr_o,
  input  wire logic                     instr_gnt_i,
  input  wire logic                     instr_rvalid_i,
  input  wire logic [ifu_pkg::XLEN-1:0] instr_rdata_i,
  input  wire logic                     instr_bus_err_i,
  input  wire logic                     pmp_err_if_i,
  // control from ID
  input  wire logic                     instr_valid_clear_i,
  input  wire logic                     pc_set_i,
  input  wire ifu_pkg::pc_sel_e         pc_mux_i,
  input  wire ifu_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  wire ifu_pkg::exc_cause_t      exc_cause_i,
  input  wire logic [ifu_pkg::XLEN-1:0] branch_target_ex_i,
  input  wire logic [ifu_pkg::XLEN-1:0] csr_mepc_i,
  input  wire logic [ifu_pkg::XLEN-1:0] csr_depc_i,
  input  wire logic [ifu_pkg::XLEN-1:0] csr_mtvec_i,
  input  wire logic                     id_in_ready_i,
  // to ID
  output logic                          instr_valid_id_o,
  output logic                          instr_new_id_o,
  output logic      [ifu_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                          instr_fetch_err_o,
  output logic      [ifu_pkg::XLEN-1:0] pc_id_o,
  output logic      [ifu_pkg::XLEN-1:0] pc_if_o,
  output logic                          csr_mtvec_init_o,
  output logic                          pc_mismatch_alert_o,
  output logic                          if_busy_o
);

  logic [ifu_pkg::XLEN-1:0] fetch_addr_n;
  logic                     fetch_valid;
  logic                     fetch_ready;
  ifu_pkg::fetch_entry_t    fetch_entry;

  ifu_pc_select pc_select_i (
    .boot_addr_i        (boot_addr_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .pc_set_i           (pc_set_i),
    .fetch_addr_n_o     (fetch_addr_n),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  // redirect reaches the bus in the same cycle
  ifu_prefetch_buffer prefetch_buffer_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .ready_i         (fetch_ready),
    .valid_o         (fetch_valid),
    .fetch_o         (fetch_entry),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .busy_o          (if_busy_o)
  );

  ifu_if_id_reg if_id_reg_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_i             (fetch_entry),
    .pmp_err_if_i        (pmp_err_if_i),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // PC of the word waiting at the FIFO head
  assign pc_if_o = fetch_entry.addr;

endmodule

`default_nettype wire

// File: sim/tb_ifu.sv
/*
  random-stimulus testbench for the fetch stage, LFSR seeded with 32'h153c
  bus memory returns the inverted address, bus error when addr[7:4] is all ones
  the model tracks requests in flight, FIFO contents and the ID register
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ifu;

  localparam int TEST_CYCLES    = 3000;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 1000;
  localparam int MIN_INSTR      = 100;

  logic                  clk_i;
  logic                  rst_ni;
  logic [31:0]           boot_addr_i;
  logic                  req_i;
  logic                  instr_req_o;
  logic [31:0]           instr_addr_o;
  logic                  instr_gnt_i;
  logic                  instr_rvalid_i;
  logic [31:0]           instr_rdata_i;
  logic                  instr_bus_err_i;
  logic                  pmp_err_if_i;
  logic                  instr_valid_clear_i;
  logic                  pc_set_i;
  ifu_pkg::pc_sel_e      pc_mux_i;
  ifu_pkg::exc_pc_sel_e  exc_pc_mux_i;
  ifu_pkg::exc_cause_t   exc_cause_i;
  logic [31:0]           branch_target_ex_i;
  logic [31:0]           csr_mepc_i;
  logic [31:0]           csr_depc_i;
  logic [31:0]           csr_mtvec_i;
  logic                  id_in_ready_i;
  logic                  instr_valid_id_o;
  logic                  instr_new_id_o;
  logic [31:0]           instr_rdata_id_o;
  logic                  instr_fetch_err_o;
  logic [31:0]           pc_id_o;
  logic [31:0]           pc_if_o;
  logic                  csr_mtvec_init_o;
  logic                  pc_mismatch_alert_o;
  logic                  if_busy_o;

  // random source and cycle bookkeeping
  logic [31:0] lfsr;
  int          cycle_cnt;
  int          n_new;

  // model state: bus side
  int          epoch;
  logic [31:0] req_addr;
  logic        req_hold;
  logic [31:0] out_addr[$];
  int          out_epoch[$];
  int          out_due[$];
  // model state: FIFO and ID register
  logic [31:0] fifo_addr[$];
  logic        fifo_err[$];
  logic        new_exp;
  logic        valid_exp;
  logic        id_err_exp;
  logic [31:0] id_pc_exp;

  ifu_if_stage dut_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .req_i               (req_i),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_bus_err_i     (instr_bus_err_i),
    .pmp_err_if_i        (pmp_err_if_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .exc_cause_i         (exc_cause_i),
    .branch_target_ex_i  (branch_target_ex_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .csr_mtvec_i         (csr_mtvec_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .if_busy_o           (if_busy_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // hard stop in case the main loop never ends
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic addr_faults(input logic [31:0] a);
    return a[7:4] == 4'hF;
  endfunction

  // redirect target from the current select inputs
  function automatic logic [31:0] expected_target();
    logic [4:0] idx;
    idx = exc_cause_i.irq_int ? 5'd31 : exc_cause_i.lower_cause;
    case (pc_mux_i)
      ifu_pkg::PC_JUMP: return branch_target_ex_i;
      ifu_pkg::PC_ERET: return csr_mepc_i;
      ifu_pkg::PC_DRET: return csr_depc_i;
      ifu_pkg::PC_EXC: begin
        case (exc_pc_mux_i)
          ifu_pkg::EXC_PC_IRQ: return (csr_mtvec_i & 32'hFFFF_FF00) + 32'(idx) * 4;
          ifu_pkg::EXC_PC_DBD: return 32'h1A11_0800;
          ifu_pkg::EXC_PC_DBG_EXC: return 32'h1A11_0808;
          default: return csr_mtvec_i & 32'hFFFF_FF00;
        endcase
      end
      default: return (boot_addr_i & 32'hFFFF_FF00) | 32'h80;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus, driven 2 ns after the rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_inputs(input int c);
    logic [31:0] r;
    // fetch enable drops now and then, a pending request must stay up
    rand_bits(3, r);
    req_i = (c >= 1) && (r[2:0] != 3'd0);
    rand_bits(5, r);
    // boot in cycle 1, then roughly one redirect in 32 cycles
    pc_set_i = (c == 1) || (c > 2 && r[4:0] == 5'd0);
    if (pc_set_i) begin
      rand_bits(3, r);
      if (c == 1) begin
        pc_mux_i = ifu_pkg::PC_BOOT;
      end else if (r[2:0] > 3'd4) begin
        pc_mux_i = ifu_pkg::PC_JUMP;
      end else begin
        pc_mux_i = ifu_pkg::pc_sel_e'(r[2:0]);
      end
      rand_bits(2, r);
      exc_pc_mux_i = ifu_pkg::exc_pc_sel_e'(r[1:0]);
      rand_bits(7, r);
      exc_cause_i = ifu_pkg::exc_cause_t'(r[6:0]);
      rand_bits(30, r);
      branch_target_ex_i = {r[29:0], 2'b00};
      rand_bits(30, r);
      csr_mepc_i = {r[29:0], 2'b00};
      rand_bits(30, r);
      csr_depc_i = {r[29:0], 2'b00};
      rand_bits(32, r);
      csr_mtvec_i = r;
    end
    rand_bits(2, r);
    id_in_ready_i = (r[1:0] != 2'd0);
    rand_bits(1, r);
    instr_valid_clear_i = r[0];
    rand_bits(4, r);
    pmp_err_if_i = (r[3:0] == 4'd0);
    rand_bits(2, r);
    instr_gnt_i = (r[1:0] != 2'd0);
    // in-order responses once the head is due
    if (out_addr.size() != 0 && out_due[0] <= c) begin
      instr_rvalid_i  = 1'b1;
      instr_rdata_i   = ~out_addr[0];
      instr_bus_err_i = addr_faults(out_addr[0]);
    end else begin
      instr_rvalid_i  = 1'b0;
      instr_rdata_i   = '0;
      instr_bus_err_i = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks at the falling edge, then model update
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_and_update(input int c);
    logic        space;
    logic        req_exp;
    logic        accept;
    logic        ep_ok;
    logic [31:0] target;
    logic [31:0] addr_exp;
    logic [31:0] a;
    logic [31:0] r;
    target   = expected_target();
    space    = (fifo_addr.size() + out_addr.size()) < int'(ifu_pkg::FIFO_DEPTH);
    // ungranted request stays up
    req_exp  = (req_i | req_hold) & space;
    addr_exp = pc_set_i ? target : req_addr;

    check_value("instr_req_o", 32'(instr_req_o), 32'(req_exp));
    if (req_exp) begin
      check_value("instr_addr_o", instr_addr_o, addr_exp);
    end
    check_value("instr_new_id_o", 32'(instr_new_id_o), 32'(new_exp));
    check_value("instr_valid_id_o", 32'(instr_valid_id_o), 32'(valid_exp));
    if (new_exp) begin
      n_new++;
      check_value("pc_id_o", pc_id_o, id_pc_exp);
      check_value("instr_rdata_id_o", instr_rdata_id_o, ~id_pc_exp);
      check_value("instr_fetch_err_o", 32'(instr_fetch_err_o), 32'(id_err_exp));
    end
    check_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o),
                32'(pc_set_i && pc_mux_i == ifu_pkg::PC_BOOT));
    check_value("if_busy_o", 32'(if_busy_o), 32'(req_exp || out_addr.size() != 0));
    check_value("pc_mismatch_alert_o", 32'(pc_mismatch_alert_o), 32'd0);
    if (fifo_addr.size() != 0) begin
      check_value("pc_if_o", pc_if_o, fifo_addr[0]);
    end

    // ID register takes the head unless redirected
    accept    = (fifo_addr.size() != 0) && id_in_ready_i && !pc_set_i;
    valid_exp = accept | (valid_exp & ~instr_valid_clear_i);
    new_exp   = accept;
    if (accept) begin
      id_pc_exp  = fifo_addr.pop_front();
      id_err_exp = fifo_err.pop_front() | pmp_err_if_i;
    end
    // stale responses vanish, so does one arriving with the redirect
    if (instr_rvalid_i) begin
      a     = out_addr.pop_front();
      ep_ok = (out_epoch.pop_front() == epoch);
      void'(out_due.pop_front());
      if (!pc_set_i && ep_ok) begin
        fifo_addr.push_back(a);
        fifo_err.push_back(addr_faults(a));
      end
    end
    if (pc_set_i) begin
      fifo_addr.delete();
      fifo_err.delete();
      epoch++;
      req_addr = target;
    end
    if (req_exp && instr_gnt_i) begin
      rand_bits(2, r);
      out_addr.push_back(addr_exp);
      out_epoch.push_back(epoch);
      out_due.push_back(c + 1 + int'(r[1:0]));
      req_addr = addr_exp + 32'd4;
    end
    req_hold = req_exp & ~instr_gnt_i;
  endtask

  initial begin
    logic [31:0] r;
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    cycle_cnt           = 0;
    lfsr                = 32'h153c;
    req_i               = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    pmp_err_if_i        = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = ifu_pkg::PC_BOOT;
    exc_pc_mux_i        = ifu_pkg::EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_ex_i  = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    id_in_ready_i       = 1'b0;
    // 256-byte aligned boot address
    rand_bits(24, r);
    boot_addr_i = {r[23:0], 8'h00};
    n_new      = 0;
    epoch      = 0;
    req_addr   = '0;
    req_hold   = 1'b0;
    new_exp    = 1'b0;
    valid_exp  = 1'b0;
    id_err_exp = 1'b0;
    id_pc_exp  = '0;

    repeat (10) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      @(posedge clk_i);
      #2 drive_inputs(cyc);
      @(negedge clk_i);
      check_and_update(cyc);
    end

    if (n_new < MIN_INSTR) begin
      $display("only %0d instructions reached ID, expected at least %0d", n_new, MIN_INSTR);
      $display("Simulation FAILED");
      $fatal(1);
    end else begin
      $display("%0d instructions checked", n_new);
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/ifu_pkg.sv
verilog/ifu_pc_select.sv
verilog/ifu_fetch_fifo.sv
verilog/ifu_prefetch_buffer.sv
verilog/ifu_if_id_reg.sv
verilog/ifu_if_stage.sv
sim/tb_ifu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the fetch stage testbench with Verilator and run it
# the run passes only if the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ifu -f tb.f -o tb_ifu_sim \
  && ./obj_dir/tb_ifu_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
  && { echo "run_sim: pass"; exit 0; } \
  || { echo "run_sim: fail"; exit 1; }
